// ==== common/core_pkg.sv ====
`default_nettype none

package core_pkg;

  localparam int WORD_W       = 32;
  localparam int PROG_ADDR_W  = 8;
  localparam int MAIN_ADDR_W  = 8;
  localparam int DSTACK_DEPTH = 16;
  localparam int CSTACK_DEPTH = 8;
  localparam int DSTACK_PTR_W = $clog2(DSTACK_DEPTH);
  localparam int CSTACK_PTR_W = $clog2(CSTACK_DEPTH);

  typedef logic [WORD_W-1:0]      word_t;
  typedef logic [PROG_ADDR_W-1:0] prog_addr_t;
  typedef logic [MAIN_ADDR_W-1:0] main_addr_t;

  // Codes missing from this list decode as a NOP
  typedef enum logic [7:0] {
    OP_NOP   = 8'h00,
    OP_PUSHI = 8'h01,
    OP_DUP   = 8'h02,
    OP_DROP  = 8'h03,
    OP_ADD   = 8'h10,
    OP_SUB   = 8'h11,
    OP_AND   = 8'h12,
    OP_OR    = 8'h13,
    OP_XOR   = 8'h14,
    OP_STORE = 8'h20,
    OP_JMPI  = 8'h30,
    OP_BZI   = 8'h31,
    OP_CALLI = 8'h32,
    OP_RET   = 8'h33,
    OP_HALT  = 8'h3f
  } opcode_t;

  // Program memory word, immediate in the upper 32 bits
  typedef struct packed {
    word_t   imm;
    opcode_t opcode;
  } prog_word_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_t;

  typedef enum logic [1:0] {
    MOVE_STAY,
    MOVE_PUSH,
    MOVE_POP,
    MOVE_POP2
  } stack_move_t;

  typedef enum logic [1:0] {
    TOP_IMM,
    TOP_TOP,
    TOP_SECOND,
    TOP_ALU
  } top_sel_t;

  typedef struct packed {
    stack_move_t move;
    top_sel_t    top_sel;
    alu_op_t     alu_op;
    logic        jump;
    logic        branch_zero;
    logic        call;
    logic        ret;
    logic        halt;
    logic        mem_we;
  } ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  core_pkg::alu_op_t op,
  input  core_pkg::word_t   a,
  input  core_pkg::word_t   b,
  output core_pkg::word_t   result
);
  import core_pkg::*;

  word_t sum;
  word_t diff;

  // Both wrap at the word width, no carry is kept
  assign sum  = a + b;
  assign diff = a - b;

  always_comb begin
    case (op)
      ALU_ADD: result = sum;
      ALU_SUB: result = diff;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      default: result = sum;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/instr_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
  input  core_pkg::opcode_t opcode,
  input  core_pkg::word_t   imm,
  input  core_pkg::word_t   top,
  input  core_pkg::word_t   second,
  input  core_pkg::word_t   alu_result,
  output core_pkg::ctrl_t   ctrl,
  output core_pkg::word_t   next_top
);
  import core_pkg::*;

  always_comb begin
    // Default is a NOP that leaves the stack untouched
    ctrl         = '0;
    ctrl.move    = MOVE_STAY;
    ctrl.top_sel = TOP_TOP;
    ctrl.alu_op  = ALU_ADD;

    case (opcode)
      OP_PUSHI: begin
        ctrl.move    = MOVE_PUSH;
        ctrl.top_sel = TOP_IMM;
      end
      OP_DUP: begin
        ctrl.move = MOVE_PUSH;
      end
      OP_DROP: begin
        ctrl.move    = MOVE_POP;
        ctrl.top_sel = TOP_SECOND;
      end
      // Two operands in, one result out, so the depth drops by one
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
        ctrl.move    = MOVE_POP;
        ctrl.top_sel = TOP_ALU;
        case (opcode)
          OP_SUB:  ctrl.alu_op = ALU_SUB;
          OP_AND:  ctrl.alu_op = ALU_AND;
          OP_OR:   ctrl.alu_op = ALU_OR;
          OP_XOR:  ctrl.alu_op = ALU_XOR;
          default: ctrl.alu_op = ALU_ADD;
        endcase
      end
      OP_STORE: begin
        ctrl.move   = MOVE_POP2;
        ctrl.mem_we = 1'b1;
      end
      OP_JMPI:  ctrl.jump = 1'b1;
      OP_BZI: begin
        ctrl.move        = MOVE_POP;
        ctrl.top_sel     = TOP_SECOND;
        ctrl.branch_zero = 1'b1;
      end
      OP_CALLI: ctrl.call = 1'b1;
      OP_RET:   ctrl.ret  = 1'b1;
      OP_HALT:  ctrl.halt = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    case (ctrl.top_sel)
      TOP_IMM:    next_top = imm;
      TOP_SECOND: next_top = second;
      TOP_ALU:    next_top = alu_result;
      default:    next_top = top;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/pc_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module pc_control (
  input  logic                 clk,
  input  logic                 rst_n,
  input  core_pkg::ctrl_t      ctrl,
  input  core_pkg::word_t      imm,
  input  core_pkg::word_t      top,
  input  core_pkg::prog_addr_t ret_addr,
  output core_pkg::prog_addr_t prog_addr,
  output core_pkg::prog_addr_t return_addr
);
  import core_pkg::*;

  // Address of the instruction executing this cycle
  prog_addr_t pc;
  prog_addr_t next_pc;
  logic       top_zero;

  assign top_zero    = (top == '0);
  assign return_addr = pc + 1'b1;

  // The memory registers this address, so it must already be the next PC.
  // Holding it at zero in reset makes word 0 execute first after release
  always_comb begin
    if (!rst_n) begin
      next_pc = '0;
    end else if (ctrl.halt) begin
      next_pc = pc;
    end else if (ctrl.ret) begin
      next_pc = ret_addr;
    end else if (ctrl.jump || ctrl.call) begin
      next_pc = imm[PROG_ADDR_W-1:0];
    end else if (ctrl.branch_zero && top_zero) begin
      next_pc = imm[PROG_ADDR_W-1:0];
    end else begin
      next_pc = return_addr;
    end
  end

  assign prog_addr = next_pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// ==== stack/data_stack.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_stack (
  input  logic                  clk,
  input  logic                  rst_n,
  input  core_pkg::stack_move_t move,
  input  core_pkg::word_t       next_top,
  output core_pkg::word_t       top,
  output core_pkg::word_t       second,
  output core_pkg::word_t       third
);
  import core_pkg::*;

  // Entries below the top, ptr is the next free slot
  word_t                   mem [DSTACK_DEPTH];
  logic [DSTACK_PTR_W-1:0] ptr;
  logic [DSTACK_PTR_W-1:0] second_idx;
  logic [DSTACK_PTR_W-1:0] third_idx;

  assign second_idx = ptr - 1'b1;
  assign third_idx  = ptr - 2'd2;
  assign second     = mem[second_idx];
  assign third      = mem[third_idx];

  // The old top spills into the array on a push
  always_ff @(posedge clk) begin
    if (move == MOVE_PUSH) begin
      mem[ptr] <= top;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
      top <= '0;
    end else begin
      case (move)
        MOVE_PUSH: begin
          ptr <= ptr + 1'b1;
          top <= next_top;
        end
        MOVE_POP: begin
          ptr <= ptr - 1'b1;
          top <= next_top;
        end
        // Both top and second are consumed, third moves up
        MOVE_POP2: begin
          ptr <= ptr - 2'd2;
          top <= third;
        end
        default: begin
          top <= next_top;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== stack/call_stack.sv ====
`timescale 1ns/1ns
`default_nettype none

module call_stack (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 push,
  input  logic                 pop,
  input  core_pkg::prog_addr_t push_addr,
  output core_pkg::prog_addr_t ret_addr
);
  import core_pkg::*;

  prog_addr_t              mem [CSTACK_DEPTH];
  logic [CSTACK_PTR_W-1:0] ptr;
  logic [CSTACK_PTR_W-1:0] top_idx;

  // Most recent return address sits just below the free slot
  assign top_idx  = ptr - 1'b1;
  assign ret_addr = mem[top_idx];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[ptr] <= push_addr;
    end
  end

  // A single instruction never calls and returns at once
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (push) begin
      ptr <= ptr + 1'b1;
    end else if (pop) begin
      ptr <= ptr - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/stack_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module stack_core (
  input  logic                 clk,
  input  logic                 rst_n,
  output core_pkg::prog_addr_t prog_addr,
  input  core_pkg::prog_word_t prog_data,
  output logic                 mem_we,
  output core_pkg::main_addr_t mem_addr,
  output core_pkg::word_t      mem_wdata
);
  import core_pkg::*;

  ctrl_t      ctrl;
  word_t      next_top;
  word_t      top;
  word_t      second;
  word_t      alu_result;
  prog_addr_t ret_addr;
  prog_addr_t return_addr;

  instr_decode u_instr_decode (
    .opcode     (prog_data.opcode),
    .imm        (prog_data.imm),
    .top        (top),
    .second     (second),
    .alu_result (alu_result),
    .ctrl       (ctrl),
    .next_top   (next_top)
  );

  // Second is the left operand so SUB computes second minus top
  alu u_alu (
    .op     (ctrl.alu_op),
    .a      (second),
    .b      (top),
    .result (alu_result)
  );

  data_stack u_data_stack (
    .clk      (clk),
    .rst_n    (rst_n),
    .move     (ctrl.move),
    .next_top (next_top),
    .top      (top),
    .second   (second),
    .third    ()
  );

  call_stack u_call_stack (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (ctrl.call),
    .pop       (ctrl.ret),
    .push_addr (return_addr),
    .ret_addr  (ret_addr)
  );

  pc_control u_pc_control (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl        (ctrl),
    .imm         (prog_data.imm),
    .top         (top),
    .ret_addr    (ret_addr),
    .prog_addr   (prog_addr),
    .return_addr (return_addr)
  );

  // STORE writes second to the address held in top
  assign mem_we    = ctrl.mem_we;
  assign mem_addr  = top[MAIN_ADDR_W-1:0];
  assign mem_wdata = second;

endmodule

`default_nettype wire

// ==== tests/clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 3
) (
  input  logic reset_req,
  output logic clk,
  output logic rst_n
);

  int   remaining;
  logic req_q;

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    remaining = RESET_CYCLES;
  end

  always #(PERIOD / 2) clk = ~clk;

  // Reset moves 2 ns after the edge and stays low for RESET_CYCLES rising edges
  always @(posedge clk) begin
    req_q = reset_req;
    #2;
    if (req_q) begin
      rst_n     = 1'b0;
      remaining = RESET_CYCLES;
    end else if (remaining > 0) begin
      remaining = remaining - 1;
      if (remaining == 0) begin
        rst_n = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/stack_core_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module stack_core_asserts (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 halt,
  input logic                 mem_we,
  input core_pkg::prog_addr_t prog_addr
);

  // The write strobe must be a clean level whenever the core runs
  a_mem_we_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(mem_we)
  ) else $error("mem_we is unknown while the core runs");

  // A halted core refetches its own HALT, so this chains on forever
  a_halt_holds: assert property (
    @(posedge clk) disable iff (!rst_n)
      halt |=> (halt && !mem_we && $stable(prog_addr))
  ) else $error("core left the halt state or wrote memory after HALT");

endmodule

bind stack_core stack_core_asserts u_stack_core_asserts (
  .clk       (clk),
  .rst_n     (rst_n),
  .halt      (ctrl.halt),
  .mem_we    (mem_we),
  .prog_addr (prog_addr)
);

`default_nettype wire

// ==== tests/stack_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module stack_core_tb;
  import core_pkg::*;

  localparam int NUM_RANDOM  = 4;
  localparam int NUM_TESTS   = 5 + NUM_RANDOM;
  localparam int TEST_CYCLES = 300;
  localparam int CLK_PERIOD  = 20;
  localparam int HOLD_CYCLES = 20;
  localparam int RANDOM_LEN  = 40;
  localparam int WATCHDOG_NS = NUM_TESTS * TEST_CYCLES * CLK_PERIOD;

  logic       clk;
  logic       rst_n;
  logic       reset_req;
  prog_addr_t prog_addr;
  prog_word_t prog_data;
  logic       mem_we;
  main_addr_t mem_addr;
  word_t      mem_wdata;

  prog_word_t prog_mem [256];
  prog_addr_t load_ptr;
  int         seed;
  string      test_name;

  // Stores predicted by the reference interpreter and consumed in order
  main_addr_t exp_addr [$];
  word_t      exp_data [$];
  int         exp_idx;
  prog_addr_t halt_addr;
  int         checks;
  int         errors;

  clock_gen #(
    .PERIOD       (CLK_PERIOD),
    .RESET_CYCLES (3)
  ) u_clock_gen (
    .reset_req (reset_req),
    .clk       (clk),
    .rst_n     (rst_n)
  );

  stack_core u_stack_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata)
  );

  // The synchronous program memory shows a word in the cycle after its address
  always @(posedge clk) begin
    prog_word_t word_q;
    word_q = prog_mem[prog_addr];
    #2;
    prog_data = word_q;
  end

  task automatic check_equal(input string name, input word_t expected, input word_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Walks the program by the instruction rules and queues every store it makes
  function automatic void predict_stores();
    word_t      stk [32];
    prog_addr_t rets [8];
    int         sp;
    int         rp;
    int         steps;
    prog_addr_t pc;
    prog_addr_t next;
    prog_word_t w;
    word_t      a;
    word_t      b;
    bit         done;
    exp_addr.delete();
    exp_data.delete();
    exp_idx = 0;
    sp      = 0;
    rp      = 0;
    steps   = 0;
    pc      = '0;
    done    = 1'b0;
    while (!done && steps < 1000) begin
      w    = prog_mem[pc];
      next = pc + 8'd1;
      case (w.opcode)
        OP_PUSHI: begin
          stk[sp] = w.imm;
          sp++;
        end
        OP_DUP: begin
          stk[sp] = stk[sp-1];
          sp++;
        end
        OP_DROP: sp--;
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
          a = stk[sp-2];
          b = stk[sp-1];
          sp--;
          case (w.opcode)
            OP_ADD:  stk[sp-1] = a + b;
            OP_SUB:  stk[sp-1] = a - b;
            OP_AND:  stk[sp-1] = a & b;
            OP_OR:   stk[sp-1] = a | b;
            default: stk[sp-1] = a ^ b;
          endcase
        end
        OP_STORE: begin
          exp_addr.push_back(stk[sp-1][7:0]);
          exp_data.push_back(stk[sp-2]);
          sp = sp - 2;
        end
        OP_JMPI: next = w.imm[7:0];
        OP_BZI: begin
          sp--;
          if (stk[sp] == '0) begin
            next = w.imm[7:0];
          end
        end
        OP_CALLI: begin
          rets[rp] = next;
          rp++;
          next = w.imm[7:0];
        end
        OP_RET: begin
          rp--;
          next = rets[rp];
        end
        OP_HALT: begin
          done = 1'b1;
          next = pc;
        end
        default: ;
      endcase
      pc = next;
      steps++;
    end
    halt_addr = pc;
  endfunction

  // Compares every store against the next predicted one
  always @(negedge clk) begin
    if (rst_n && mem_we) begin
      if (exp_idx >= exp_addr.size()) begin
        errors++;
        $display("ERROR %s: unexpected store of %h to address %h", test_name, mem_wdata,
                 mem_addr);
      end else begin
        check_equal({test_name, " store address"}, 32'(exp_addr[exp_idx]), 32'(mem_addr));
        check_equal({test_name, " store data"}, exp_data[exp_idx], mem_wdata);
        exp_idx++;
      end
    end
  end

  // Every word that the program does not set is a HALT
  task automatic clear_program();
    for (int i = 0; i < 256; i++) begin
      prog_mem[i] = '{imm: word_t'(i), opcode: OP_HALT};
    end
    load_ptr = '0;
  endtask

  task automatic emit(input opcode_t op, input word_t imm);
    prog_mem[load_ptr] = '{imm: imm, opcode: op};
    load_ptr++;
  endtask

  task automatic emit_binary(input opcode_t op, input word_t a, input word_t b,
                             input word_t addr);
    emit(OP_PUSHI, a);
    emit(OP_PUSHI, b);
    emit(op, '0);
    emit(OP_PUSHI, addr);
    emit(OP_STORE, '0);
  endtask

  task automatic emit_store_const(input word_t data, input word_t addr);
    emit(OP_PUSHI, data);
    emit(OP_PUSHI, addr);
    emit(OP_STORE, '0);
  endtask

  task automatic build_arith();
    clear_program();
    emit_binary(OP_ADD, 32'hffff_fff0, 32'h0000_0025, 32'h30);
    emit_binary(OP_SUB, 32'h0000_0003, 32'h0000_0005, 32'h31);
    emit_binary(OP_AND, 32'hf0f0_1234, 32'h0ff0_ff00, 32'h32);
    emit_binary(OP_OR,  32'hf000_1001, 32'h000f_1003, 32'h33);
    emit_binary(OP_XOR, 32'hdead_beef, 32'hffff_0000, 32'h34);
    emit(OP_HALT, '0);
  endtask

  task automatic build_stack_moves();
    clear_program();
    emit(OP_PUSHI, 32'h11);
    emit(OP_PUSHI, 32'h22);
    emit(OP_DUP, '0);
    emit(OP_PUSHI, 32'h40);
    emit(OP_STORE, '0);
    emit(OP_DROP, '0);
    emit(OP_PUSHI, 32'h41);
    emit(OP_STORE, '0);
    emit(OP_PUSHI, 32'h5);
    emit(OP_PUSHI, 32'h6);
    emit(OP_PUSHI, 32'h7);
    emit(OP_DROP, '0);
    emit(OP_PUSHI, 32'h42);
    emit(OP_STORE, '0);
    emit(OP_DUP, '0);
    emit(OP_PUSHI, 32'h43);
    emit(OP_STORE, '0);
    emit(OP_HALT, '0);
  endtask

  // Addresses in the comments are word positions in program memory
  task automatic build_flow();
    clear_program();
    emit_store_const(32'h1, 32'h50);
    emit(OP_JMPI, 32'd7);
    emit_store_const(32'hbad, 32'h51);
    emit(OP_PUSHI, 32'h0);
    emit(OP_BZI, 32'd12);
    emit_store_const(32'hbad, 32'h54);
    // At 12 a nonzero value falls through the branch
    emit(OP_PUSHI, 32'h7);
    emit(OP_BZI, 32'd17);
    emit_store_const(32'h3, 32'h52);
    emit_store_const(32'h4, 32'h53);
    emit(OP_HALT, '0);
  endtask

  task automatic build_calls();
    clear_program();
    emit_store_const(32'h1, 32'h60);
    emit(OP_CALLI, 32'd10);
    emit_store_const(32'h7, 32'h65);
    emit(OP_HALT, '0);
    load_ptr = 8'd10;
    emit_store_const(32'h2, 32'h61);
    emit(OP_CALLI, 32'd20);
    emit_store_const(32'h6, 32'h64);
    emit(OP_RET, '0);
    load_ptr = 8'd20;
    emit_store_const(32'h3, 32'h62);
    emit(OP_CALLI, 32'd30);
    emit_store_const(32'h5, 32'h63);
    emit(OP_RET, '0);
    load_ptr = 8'd30;
    emit_store_const(32'h4, 32'h66);
    emit(OP_RET, '0);
  endtask

  task automatic build_halt();
    clear_program();
    emit_store_const(32'h77, 32'h70);
    emit(OP_HALT, '0);
    emit_store_const(32'h1, 32'h71);
    emit(OP_HALT, '0);
  endtask

  // Straight-line code whose stack depth stays between 2 and 15
  task automatic build_random();
    opcode_t alu_ops [5];
    int      depth;
    int      kind;
    alu_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
    clear_program();
    emit(OP_PUSHI, word_t'($random(seed)));
    emit(OP_PUSHI, word_t'($random(seed)));
    depth = 2;
    repeat (RANDOM_LEN - 3) begin
      kind = int'($unsigned($random(seed)) % 8);
      if (kind <= 3 && depth >= 15) kind = 4;
      if (kind >= 4 && kind <= 5 && depth < 3) kind = 0;
      if (kind >= 6 && depth < 4) kind = 0;
      if (kind <= 2) begin
        emit(OP_PUSHI, word_t'($random(seed)));
        depth++;
      end else if (kind == 3) begin
        emit(OP_DUP, '0);
        depth++;
      end else if (kind <= 5) begin
        emit(alu_ops[$unsigned($random(seed)) % 5], '0);
        depth--;
      end else begin
        emit(OP_STORE, '0);
        depth = depth - 2;
      end
    end
    emit(OP_HALT, '0);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #2;
    reset_req = 1'b1;
    @(posedge clk);
    #2;
    reset_req = 1'b0;
    wait (rst_n == 1'b0);
  endtask

  // Runs the loaded program until HALT, then watches the halted core
  task automatic run_test(input string name);
    int cycles;
    test_name = name;
    predict_stores();
    wait (rst_n == 1'b1);
    cycles = 0;
    @(negedge clk);
    while (prog_data.opcode != OP_HALT && cycles < TEST_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (prog_data.opcode != OP_HALT) begin
      errors++;
      $display("ERROR %s: program did not reach HALT within %0d cycles", name, TEST_CYCLES);
    end else begin
      repeat (HOLD_CYCLES) begin
        @(negedge clk);
        check_equal({name, " halt address"}, 32'(halt_addr), 32'(prog_addr));
      end
    end
    if (exp_idx != exp_addr.size()) begin
      errors++;
      $display("ERROR %s: only %0d of %0d expected stores happened before halt", name,
               exp_idx, exp_addr.size());
    end
  endtask

  initial begin
    seed      = 32'hcdc8;
    reset_req = 1'b0;
    prog_data = '0;
    checks    = 0;
    errors    = 0;
    exp_idx   = 0;
    halt_addr = '0;
    test_name = "idle";
    clear_program();

    apply_reset();
    build_arith();
    run_test("arith");
    apply_reset();
    build_stack_moves();
    run_test("stack_moves");
    apply_reset();
    build_flow();
    run_test("flow");
    apply_reset();
    build_calls();
    run_test("calls");
    apply_reset();
    build_halt();
    run_test("halt");
    for (int n = 0; n < NUM_RANDOM; n++) begin
      apply_reset();
      build_random();
      run_test($sformatf("random_%0d", n));
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
common/core_pkg.sv
verilog/alu.sv
verilog/instr_decode.sv
verilog/pc_control.sv
stack/data_stack.sv
stack/call_stack.sv
verilog/stack_core.sv
tests/clock_gen.sv
tests/stack_core_asserts.sv
tests/stack_core_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module stack_core_tb -f compile.f -o sim

out=$(./obj_dir/sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
exit 1
